// ==== sim/tb_rename_top.sv ====
// Self-checking testbench for rename_top driving directed and LFSR instructions against a model
`timescale 1ns/1ns

module tb_rename_top;

    logic        clk = 1'b0;
    logic        rst;
    logic        inst_req;
    logic [31:0] inst_word;
    logic        rs_full;
    logic        cdb_valid;
    logic        commit_valid;
    logic [5:0]  cdb_preg, commit_preg;
    logic        inst_ack, disp_valid, disp_rs1_ready, disp_rs2_ready;
    logic [2:0]  disp_rob_id;
    logic [6:0]  disp_opcode;
    logic [31:0] disp_imm;
    logic [5:0]  disp_prs1, disp_prs2, disp_prd, disp_old_prd;

    // Reference alias map, free list, pending bits and ROB counter
    int          map_m [32];
    int          free_m [$];
    bit          busy_m [64];
    int          rob_m;
    int          last_old;
    int          errors;
    int          checks;
    int          tests;
    int          test_errors;
    logic [31:0] lfsr;

    rename_top u_dut (
        .clk(clk), .rst(rst), .inst_req(inst_req), .inst_word(inst_word), .rs_full(rs_full),
        .cdb_valid(cdb_valid), .cdb_preg(cdb_preg), .commit_valid(commit_valid),
        .commit_preg(commit_preg), .inst_ack(inst_ack), .disp_valid(disp_valid),
        .disp_rob_id(disp_rob_id), .disp_opcode(disp_opcode), .disp_imm(disp_imm),
        .disp_prs1(disp_prs1), .disp_prs2(disp_prs2), .disp_prd(disp_prd),
        .disp_old_prd(disp_old_prd), .disp_rs1_ready(disp_rs1_ready),
        .disp_rs2_ready(disp_rs2_ready)
    );

    always #5 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [6:0] pick_op(input logic [31:0] sel);
        case (sel[2:0])
            3'd0:    return rename_pkg::op_reg;
            3'd1:    return rename_pkg::op_imm;
            3'd2:    return rename_pkg::op_load;
            3'd3:    return rename_pkg::op_store;
            3'd4:    return rename_pkg::op_branch;
            3'd5:    return rename_pkg::op_lui;
            3'd6:    return rename_pkg::op_imm;
            default: return 7'b1111111;
        endcase
    endfunction

    function automatic logic [31:0] encode(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'h5a, rs2, rs1, 3'b010, rd, op};
    endfunction

    task automatic wait_ack(input logic level, output int cycles);
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (inst_ack !== level && cycles < 50);
        if (inst_ack !== level) begin
            $display("timeout while waiting for inst_ack to become %0d", level);
            $display("Verification failed");
            $finish;
        end
    endtask

    // One four-phase transfer with a stall released by rs_full or by a commit of release_preg
    task automatic issue(input logic [31:0] w, input int stall, input int release_preg,
                         input int bypass_preg);
        logic [6:0]  op;
        logic [31:0] imm;
        logic        n1;
        logic        n2;
        logic        alloc;
        logic        r1;
        logic        r2;
        int          new_prd;
        int          old_prd;
        int          cycles;
        op = w[6:0];
        n1 = (op == rename_pkg::op_reg) || (op == rename_pkg::op_imm) ||
             (op == rename_pkg::op_load) || (op == rename_pkg::op_store) ||
             (op == rename_pkg::op_branch);
        n2 = (op == rename_pkg::op_reg) || (op == rename_pkg::op_store) ||
             (op == rename_pkg::op_branch);
        alloc = (w[11:7] != 0) && ((op == rename_pkg::op_reg) || (op == rename_pkg::op_imm) ||
                                   (op == rename_pkg::op_load) || (op == rename_pkg::op_lui));
        case (w[6:0])
            rename_pkg::op_imm, rename_pkg::op_load: imm = {{20{w[31]}}, w[31:20]};
            rename_pkg::op_store: imm = {{20{w[31]}}, w[31:25], w[11:7]};
            rename_pkg::op_lui:   imm = {w[31:12], 12'b0};
            default:              imm = '0;
        endcase
        inst_word = w;
        inst_req  = 1'b1;
        if (bypass_preg > 0) begin
            cdb_valid = 1'b1;
            cdb_preg  = bypass_preg;
        end
        repeat (stall) begin
            @(posedge clk);
            #1;
            check_val("inst_ack", inst_ack, 0);
            check_val("disp_valid", disp_valid, 0);
        end
        if (stall > 0 && release_preg > 0) begin
            commit_valid = 1'b1;
            commit_preg  = release_preg;
            @(posedge clk);
            #1;
            commit_valid = 1'b0;
            free_m.push_back(release_preg);
        end else if (stall > 0) begin
            rs_full = 1'b0;
        end
        new_prd = alloc ? free_m[0] : 0;
        old_prd = alloc ? map_m[w[11:7]] : 0;
        r1 = !n1 || !(busy_m[map_m[w[19:15]]] && map_m[w[19:15]] != bypass_preg);
        r2 = !n2 || !(busy_m[map_m[w[24:20]]] && map_m[w[24:20]] != bypass_preg);
        wait_ack(1'b1, cycles);
        cdb_valid = 1'b0;
        check_val("inst_ack_cycles", cycles, 1);
        check_val("disp_valid", disp_valid, 1);
        check_val("disp_rob_id", disp_rob_id, rob_m % rename_pkg::rob_depth);
        check_val("disp_opcode", disp_opcode, w[6:0]);
        check_val("disp_imm", disp_imm, imm);
        if (n1) check_val("disp_prs1", disp_prs1, map_m[w[19:15]]);
        if (n2) check_val("disp_prs2", disp_prs2, map_m[w[24:20]]);
        check_val("disp_prd", disp_prd, new_prd);
        check_val("disp_old_prd", disp_old_prd, old_prd);
        check_val("disp_rs1_ready", disp_rs1_ready, r1);
        check_val("disp_rs2_ready", disp_rs2_ready, r2);
        if (bypass_preg > 0) busy_m[bypass_preg] = 1'b0;
        if (alloc) begin
            map_m[w[11:7]]  = new_prd;
            busy_m[new_prd] = 1'b1;
            new_prd         = free_m.pop_front();
            last_old        = old_prd;
        end
        rob_m++;
        inst_req = 1'b0;
        wait_ack(1'b0, cycles);
        check_val("inst_ack_fall_cycles", cycles, 1);
        check_val("disp_valid", disp_valid, 0);
    endtask

    task automatic complete(input int preg);
        cdb_valid = 1'b1;
        cdb_preg  = preg;
        @(posedge clk);
        #1;
        cdb_valid    = 1'b0;
        busy_m[preg] = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        logic [31:0] w;
        int          p;
        errors = 0;
        checks = 0;
        tests = 0;
        test_errors = 0;
        rob_m = 0;
        last_old = 0;
        lfsr = 32'd68130;
        for (int i = 0; i < 32; i++) map_m[i] = i;
        for (int i = 32; i < 64; i++) free_m.push_back(i);
        rst = 1'b1;
        inst_req = 1'b0;
        inst_word = '0;
        rs_full = 1'b0;
        cdb_valid = 1'b0;
        cdb_preg = '0;
        commit_valid = 1'b0;
        commit_preg = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        check_val("inst_ack", inst_ack, 0);
        check_val("disp_valid", disp_valid, 0);
        issue(encode(rename_pkg::op_reg, 5'd3, 5'd1, 5'd2), 0, 0, 0);
        check_val("disp_prd", disp_prd, 32);
        check_val("disp_old_prd", disp_old_prd, 3);
        end_test("reset state");
        issue(encode(rename_pkg::op_store, 5'd4, 5'd3, 5'd2), 0, 0, 0);
        issue(encode(rename_pkg::op_load, 5'd5, 5'd3, 5'd0), 0, 0, 0);
        end_test("handshake and timing");
        // Keep a few free registers in reserve for the directed tests
        for (int k = 0; k < 40; k++) begin
            w = lfsr_bits(25) << 7;
            w[6:0] = pick_op(lfsr_bits(3));
            if (free_m.size() <= 6) w[11:7] = 5'd0;
            issue(w, 0, 0, 0);
        end
        end_test("renaming chain");
        issue(encode(rename_pkg::op_imm, 5'd10, 5'd0, 5'd0), 0, 0, 0);
        p = map_m[10];
        issue(encode(rename_pkg::op_reg, 5'd12, 5'd10, 5'd0), 0, 0, 0);
        check_val("disp_rs1_ready", disp_rs1_ready, 0);
        issue(encode(rename_pkg::op_lui, 5'd13, 5'd10, 5'd10), 0, 0, 0);
        check_val("disp_rs1_ready", disp_rs1_ready, 1);
        complete(p);
        issue(encode(rename_pkg::op_reg, 5'd14, 5'd10, 5'd0), 0, 0, 0);
        check_val("disp_rs1_ready", disp_rs1_ready, 1);
        issue(encode(rename_pkg::op_imm, 5'd11, 5'd0, 5'd0), 0, 0, 0);
        issue(encode(rename_pkg::op_store, 5'd0, 5'd11, 5'd11), 0, 0, map_m[11]);
        check_val("disp_rs1_ready", disp_rs1_ready, 1);
        end_test("readiness");
        rs_full = 1'b1;
        issue(encode(rename_pkg::op_imm, 5'd9, 5'd1, 5'd0), 5, -1, 0);
        while (free_m.size() > 0) issue(encode(rename_pkg::op_imm, 5'd7, 5'd7, 5'd0), 0, 0, 0);
        p = last_old;
        issue(encode(rename_pkg::op_reg, 5'd8, 5'd7, 5'd7), 4, p, 0);
        check_val("disp_prd", disp_prd, p);
        end_test("back-pressure");
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== src/busy_table.sv ====
// Pending-result bits per physical register with same-cycle completion bypass on lookup
`timescale 1ns/1ns

module busy_table (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [rename_pkg::preg_w-1:0] prs1,
    input  logic [rename_pkg::preg_w-1:0] prs2,
    input  logic                          set_en,
    input  logic [rename_pkg::preg_w-1:0] set_preg,
    input  logic                          cdb_valid,
    input  logic [rename_pkg::preg_w-1:0] cdb_preg,
    output logic                          rs1_busy,
    output logic                          rs2_busy
);

    logic [rename_pkg::phys_regs-1:0] busy_q;

    // A completion arriving this cycle already counts as ready
    assign rs1_busy = (prs1 != '0) && busy_q[prs1] && !(cdb_valid && (cdb_preg == prs1));
    assign rs2_busy = (prs2 != '0) && busy_q[prs2] && !(cdb_valid && (cdb_preg == prs2));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= '0;
        end else begin
            if (cdb_valid) begin
                busy_q[cdb_preg] <= 1'b0;
            end
            // New destination is fresh from the free list, so no clash with the clear
            if (set_en && (set_preg != '0)) begin
                busy_q[set_preg] <= 1'b1;
            end
        end
    end

endmodule

// ==== src/inst_decoder.sv ====
// Combinational RV32I decoder giving register fields, usage flags and immediate to rename
`timescale 1ns/1ns

module inst_decoder (
    input  rename_pkg::inst_word_u inst_word,
    output logic [4:0]             rs1,
    output logic [4:0]             rs2,
    output logic [4:0]             rd,
    output logic                   rs1_needed,
    output logic                   rs2_needed,
    output logic                   rd_write,
    output logic [31:0]            imm,
    output logic [6:0]             opcode
);

    // Opcode sits in the same bits in both views
    assign opcode = inst_word.reg_view.opcode;

    always_comb begin
        rs1        = '0;
        rs2        = '0;
        rd         = '0;
        rs1_needed = 1'b0;
        rs2_needed = 1'b0;
        rd_write   = 1'b0;
        imm        = '0;
        case (inst_word.reg_view.opcode)
            rename_pkg::op_reg: begin
                rs1        = inst_word.reg_view.rs1;
                rs2        = inst_word.reg_view.rs2;
                rd         = inst_word.reg_view.rd;
                rs1_needed = 1'b1;
                rs2_needed = 1'b1;
                rd_write   = 1'b1;
            end
            rename_pkg::op_store: begin
                rs1        = inst_word.reg_view.rs1;
                rs2        = inst_word.reg_view.rs2;
                rs1_needed = 1'b1;
                rs2_needed = 1'b1;
                // S immediate is split over funct7 and the rd slot
                imm = {{20{inst_word.reg_view.funct7[6]}}, inst_word.reg_view.funct7,
                       inst_word.reg_view.rd};
            end
            rename_pkg::op_branch: begin
                rs1        = inst_word.reg_view.rs1;
                rs2        = inst_word.reg_view.rs2;
                rs1_needed = 1'b1;
                rs2_needed = 1'b1;
            end
            rename_pkg::op_imm, rename_pkg::op_load: begin
                rs1        = inst_word.imm_view.rs1;
                rd         = inst_word.imm_view.rd;
                rs1_needed = 1'b1;
                rd_write   = 1'b1;
                imm        = {{20{inst_word.imm_view.imm12[11]}}, inst_word.imm_view.imm12};
            end
            rename_pkg::op_lui: begin
                rd       = inst_word.imm_view.rd;
                rd_write = 1'b1;
                imm      = {inst_word.imm_view.imm12, inst_word.imm_view.rs1,
                            inst_word.imm_view.funct3, 12'b0};
            end
            default: begin
                // Unknown opcode reads and writes no register
            end
        endcase
    end

endmodule

// ==== src/rename_dispatch.sv ====
// Four-phase instruction handshake, rename sequencing and registered reservation-station entry
`timescale 1ns/1ns

module rename_dispatch (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            inst_req,
    input  logic [31:0]                     inst_word_in,
    input  logic                            rs_full,
    input  logic                            free_avail,
    input  logic                            rs1_needed,
    input  logic                            rs2_needed,
    input  logic                            rd_write,
    input  logic [4:0]                      rd,
    input  logic [31:0]                     imm,
    input  logic [6:0]                      opcode,
    input  logic [rename_pkg::preg_w-1:0]   prs1,
    input  logic [rename_pkg::preg_w-1:0]   prs2,
    input  logic [rename_pkg::preg_w-1:0]   old_prd,
    input  logic [rename_pkg::preg_w-1:0]   new_prd,
    input  logic                            rs1_busy,
    input  logic                            rs2_busy,
    output logic                            inst_ack,
    output rename_pkg::inst_word_u          inst_word,
    output logic                            rename_en,
    output logic                            alloc,
    output logic                            disp_valid,
    output logic [rename_pkg::rob_id_w-1:0] disp_rob_id,
    output logic [6:0]                      disp_opcode,
    output logic [31:0]                     disp_imm,
    output logic [rename_pkg::preg_w-1:0]   disp_prs1,
    output logic [rename_pkg::preg_w-1:0]   disp_prs2,
    output logic [rename_pkg::preg_w-1:0]   disp_prd,
    output logic [rename_pkg::preg_w-1:0]   disp_old_prd,
    output logic                            disp_rs1_ready,
    output logic                            disp_rs2_ready
);

    // Handshake FSM state where low is idle and high is acked
    logic                            acked_q;
    logic [rename_pkg::rob_id_w-1:0] rob_id_q;
    logic                            rs1_ready;
    logic                            rs2_ready;

    assign inst_word = inst_word_in;
    assign inst_ack  = acked_q;

    // x0 destinations are dropped, so only real writes take a register
    assign alloc = rd_write && (rd != '0);

    // One rename per request, held off by a full RS or an empty free list
    assign rename_en = inst_req && !acked_q && !rs_full && (!alloc || free_avail);

    assign rs1_ready = !rs1_needed || !rs1_busy;
    assign rs2_ready = !rs2_needed || !rs2_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            acked_q    <= 1'b0;
            disp_valid <= 1'b0;
            rob_id_q   <= '0;
        end else begin
            disp_valid <= rename_en;
            if (rename_en) begin
                acked_q  <= 1'b1;
                rob_id_q <= rob_id_q + 1'b1;
            end else if (acked_q && !inst_req) begin
                acked_q <= 1'b0;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (rename_en) begin
            disp_rob_id    <= rob_id_q;
            disp_opcode    <= opcode;
            disp_imm       <= imm;
            disp_prs1      <= prs1;
            disp_prs2      <= prs2;
            disp_prd       <= new_prd;
            disp_old_prd   <= old_prd;
            disp_rs1_ready <= rs1_ready;
            disp_rs2_ready <= rs2_ready;
        end
    end

endmodule

// ==== src/rename_pkg.sv ====
// Shared sizes, RV32I opcodes and instruction-word views for the rename and dispatch front
package rename_pkg;

    // Register file sizes
    localparam int arch_regs = 32;
    localparam int phys_regs = 64;
    localparam int preg_w    = 6;

    // ROB tagging
    localparam int rob_depth = 8;
    localparam int rob_id_w  = 3;

    // RV32I major opcodes that the decoder recognizes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_lui    = 7'b0110111;

    // One instruction word, seen either as R/S/B layout or as I/U layout
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } reg_view;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } imm_view;
    } inst_word_u;

endpackage

// ==== src/rename_table.sv ====
// Register alias table and circular free list, popped on rename and pushed on commit
`timescale 1ns/1ns

module rename_table (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [4:0]                    rs1,
    input  logic [4:0]                    rs2,
    input  logic [4:0]                    rd,
    input  logic                          alloc,
    input  logic                          rename_en,
    input  logic                          commit_valid,
    input  logic [rename_pkg::preg_w-1:0] commit_preg,
    output logic [rename_pkg::preg_w-1:0] prs1,
    output logic [rename_pkg::preg_w-1:0] prs2,
    output logic [rename_pkg::preg_w-1:0] old_prd,
    output logic [rename_pkg::preg_w-1:0] new_prd,
    output logic                          free_avail
);

    logic [rename_pkg::preg_w-1:0] map_q [rename_pkg::arch_regs];
    logic [rename_pkg::preg_w-1:0] free_q [rename_pkg::phys_regs - rename_pkg::arch_regs];

    // Pointers wrap on their own since the free list depth is a power of two
    logic [$clog2(rename_pkg::phys_regs - rename_pkg::arch_regs)-1:0] head_q;
    logic [$clog2(rename_pkg::phys_regs - rename_pkg::arch_regs)-1:0] tail_q;
    logic [rename_pkg::preg_w-1:0] count_q;

    logic pop;
    logic push;

    assign pop  = rename_en && alloc;
    // Physical register 0 backs x0 and never returns to the pool
    assign push = commit_valid && (commit_preg != '0);

    assign prs1       = map_q[rs1];
    assign prs2       = map_q[rs2];
    assign old_prd    = alloc ? map_q[rd] : '0;
    assign new_prd    = alloc ? free_q[head_q] : '0;
    assign free_avail = (count_q != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity map with every register above the architectural range free
            for (int i = 0; i < rename_pkg::arch_regs; i++) begin
                map_q[i] <= rename_pkg::preg_w'(i);
            end
            for (int i = 0; i < rename_pkg::phys_regs - rename_pkg::arch_regs; i++) begin
                free_q[i] <= rename_pkg::preg_w'(rename_pkg::arch_regs + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= rename_pkg::preg_w'(rename_pkg::phys_regs - rename_pkg::arch_regs);
        end else begin
            if (pop) begin
                map_q[rd] <= free_q[head_q];
                head_q    <= head_q + 1'b1;
            end
            if (push) begin
                free_q[tail_q] <= commit_preg;
                tail_q         <= tail_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// ==== src/rename_top.sv ====
// Top level of the rename front, wiring decoder, alias table, busy table and dispatch
`timescale 1ns/1ns

module rename_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            inst_req,
    input  logic [31:0]                     inst_word,
    input  logic                            rs_full,
    input  logic                            cdb_valid,
    input  logic [rename_pkg::preg_w-1:0]   cdb_preg,
    input  logic                            commit_valid,
    input  logic [rename_pkg::preg_w-1:0]   commit_preg,
    output logic                            inst_ack,
    output logic                            disp_valid,
    output logic [rename_pkg::rob_id_w-1:0] disp_rob_id,
    output logic [6:0]                      disp_opcode,
    output logic [31:0]                     disp_imm,
    output logic [rename_pkg::preg_w-1:0]   disp_prs1,
    output logic [rename_pkg::preg_w-1:0]   disp_prs2,
    output logic [rename_pkg::preg_w-1:0]   disp_prd,
    output logic [rename_pkg::preg_w-1:0]   disp_old_prd,
    output logic                            disp_rs1_ready,
    output logic                            disp_rs2_ready
);

    rename_pkg::inst_word_u        dec_word;
    logic [4:0]                    rs1, rs2, rd;
    logic                          rs1_needed, rs2_needed, rd_write;
    logic [31:0]                   imm;
    logic [6:0]                    opcode;
    logic [rename_pkg::preg_w-1:0] prs1, prs2, old_prd, new_prd;
    logic                          free_avail, rename_en, alloc;
    logic                          rs1_busy, rs2_busy;

    inst_decoder u_decoder (
        .inst_word(dec_word), .rs1(rs1), .rs2(rs2), .rd(rd),
        .rs1_needed(rs1_needed), .rs2_needed(rs2_needed), .rd_write(rd_write),
        .imm(imm), .opcode(opcode)
    );

    rename_table u_rename_table (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd), .alloc(alloc),
        .rename_en(rename_en), .commit_valid(commit_valid), .commit_preg(commit_preg),
        .prs1(prs1), .prs2(prs2), .old_prd(old_prd), .new_prd(new_prd),
        .free_avail(free_avail)
    );

    // new_prd reads 0 without allocation, which the busy table ignores
    busy_table u_busy_table (
        .clk(clk), .rst(rst), .prs1(prs1), .prs2(prs2), .set_en(rename_en),
        .set_preg(new_prd), .cdb_valid(cdb_valid), .cdb_preg(cdb_preg),
        .rs1_busy(rs1_busy), .rs2_busy(rs2_busy)
    );

    rename_dispatch u_dispatch (
        .clk(clk), .rst(rst), .inst_req(inst_req), .inst_word_in(inst_word),
        .rs_full(rs_full), .free_avail(free_avail), .rs1_needed(rs1_needed),
        .rs2_needed(rs2_needed), .rd_write(rd_write), .rd(rd), .imm(imm), .opcode(opcode),
        .prs1(prs1), .prs2(prs2), .old_prd(old_prd), .new_prd(new_prd),
        .rs1_busy(rs1_busy), .rs2_busy(rs2_busy), .inst_ack(inst_ack), .inst_word(dec_word),
        .rename_en(rename_en), .alloc(alloc), .disp_valid(disp_valid),
        .disp_rob_id(disp_rob_id), .disp_opcode(disp_opcode), .disp_imm(disp_imm),
        .disp_prs1(disp_prs1), .disp_prs2(disp_prs2), .disp_prd(disp_prd),
        .disp_old_prd(disp_old_prd), .disp_rs1_ready(disp_rs1_ready),
        .disp_rs2_ready(disp_rs2_ready)
    );

endmodule

// ==== verilog.f ====
src/rename_pkg.sv
src/inst_decoder.sv
src/rename_table.sv
src/busy_table.sv
src/rename_dispatch.sv
src/rename_top.sv
sim/tb_rename_top.sv
